//--- include/kbd_settings.svh
`ifndef KBD_SETTINGS_SVH
`define KBD_SETTINGS_SVH

// ----------------------------------------------------------------------
// PS/2 front end settings
// ----------------------------------------------------------------------

// flip-flops in each of the ps2_clk and ps2_data synchronizers, 2 to 4.
`define KBD_SYNC_STAGES 3

// scan-code prefixes of scan code set 2.
`define KBD_BREAK_CODE 8'hF0
`define KBD_EXT_CODE   8'hE0

`endif

//--- hdl/kbd_pkg.sv
package kbd_pkg;

	// the receiver word is either the scan byte or the frame error flags.
	typedef union packed {
		logic [7:0] code;
		struct packed {
			logic [5:0] unused;
			logic       stop_err;
			logic       parity_err;
		} err;
	} ps2_word_u;

	localparam logic [7:0] SEG_BLANK = 8'hFF; // active low, so all segments dark.

	// segments a..g sit in bits 7..1, bit 0 is the decimal point.
	function automatic logic [7:0] hex_to_seg(input logic [3:0] nibble);
		logic [7:0] pat;
		case (nibble)
			4'h0: pat = 8'b1111_1100;
			4'h1: pat = 8'b0110_0000;
			4'h2: pat = 8'b1101_1010;
			4'h3: pat = 8'b1111_0010;
			4'h4: pat = 8'b0110_0110;
			4'h5: pat = 8'b1011_0110;
			4'h6: pat = 8'b1011_1110;
			4'h7: pat = 8'b1110_0000;
			4'h8: pat = 8'b1111_1110;
			4'h9: pat = 8'b1111_0110;
			4'hA: pat = 8'b1110_1110;
			4'hB: pat = 8'b0011_1110;
			4'hC: pat = 8'b1001_1100;
			4'hD: pat = 8'b0111_1010;
			4'hE: pat = 8'b1001_1110;
			default: pat = 8'b1000_1110;
		endcase
		return ~pat; // the panel lights a segment on a low level.
	endfunction

endpackage

//--- hdl/ps2_frame_rx.sv
`timescale 1ns/1ns
`include "kbd_settings.svh"

module ps2_frame_rx import kbd_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      ps2_clk,
	input  logic      ps2_data,
	input  logic      nextdata_n,
	output ps2_word_u rx_word,
	output logic      rx_err,
	output logic      rx_ready
);

	logic [`KBD_SYNC_STAGES-1:0] clk_sync;
	logic [`KBD_SYNC_STAGES-1:0] data_sync;
	logic                        clk_prev;
	logic                        clk_fall;
	logic                        data_s;
	logic [10:0]                 shift_reg;
	logic [3:0]                  bit_count;
	logic                        frame_done;
	logic                        parity_err;
	logic                        stop_err;

	// ----------------------------------------------------------------------
	// synchronizers and falling edge detect
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			clk_sync  <= '1; // both lines idle high.
			data_sync <= '1;
			clk_prev  <= 1'b1;
		end else begin
			clk_sync  <= {clk_sync[`KBD_SYNC_STAGES-2:0], ps2_clk};
			data_sync <= {data_sync[`KBD_SYNC_STAGES-2:0], ps2_data};
			clk_prev  <= clk_sync[`KBD_SYNC_STAGES-1];
		end
	end

	assign clk_fall = clk_prev & ~clk_sync[`KBD_SYNC_STAGES-1];
	assign data_s   = data_sync[`KBD_SYNC_STAGES-1]; // same delay as the clock path.

	// ----------------------------------------------------------------------
	// frame assembly
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (clk_fall) begin
			shift_reg <= {data_s, shift_reg[10:1]}; // lsb first, start bit ends in bit 0.
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			bit_count  <= 4'd0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			if (clk_fall) begin
				if (bit_count == 4'd0 && data_s) begin
					bit_count <= 4'd0; // a high start bit is noise, so wait for a real one.
				end else if (bit_count == 4'd10) begin
					bit_count  <= 4'd0;
					frame_done <= 1'b1;
				end else begin
					bit_count <= bit_count + 4'd1;
				end
			end
		end
	end

	// ----------------------------------------------------------------------
	// checks and result holding
	// ----------------------------------------------------------------------

	assign parity_err = ~(^shift_reg[9:1]); // data plus parity must hold an odd count of ones.
	assign stop_err   = ~shift_reg[10];

	always_ff @(posedge clk) begin
		if (frame_done) begin
			rx_err <= parity_err | stop_err;
			if (parity_err || stop_err) begin
				rx_word.err.unused     <= '0;
				rx_word.err.stop_err   <= stop_err;
				rx_word.err.parity_err <= parity_err;
			end else begin
				rx_word.code <= shift_reg[8:1];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rx_ready <= 1'b0;
		end else if (frame_done) begin
			rx_ready <= 1'b1; // a newer frame simply replaces an unread word.
		end else if (!nextdata_n) begin
			rx_ready <= 1'b0;
		end
	end

endmodule

//--- hdl/scan_decoder.sv
`timescale 1ns/1ns
`include "kbd_settings.svh"

module scan_decoder import kbd_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  ps2_word_u  rx_word,
	input  logic       rx_err,
	input  logic       rx_ready,
	output logic       nextdata_n,
	output logic       key_valid,
	output logic [7:0] key_code,
	output logic       key_break,
	output logic       key_ext,
	output logic       frame_err
);

	logic consume;
	logic pend_break;
	logic pend_ext;
	logic is_prefix;

	// the word is read in the cycle that nextdata_n is low.
	assign consume   = rx_ready & ~nextdata_n;
	assign is_prefix = (rx_word.code == `KBD_BREAK_CODE) || (rx_word.code == `KBD_EXT_CODE);

	// ----------------------------------------------------------------------
	// handshake and event pulses
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			nextdata_n <= 1'b1;
			key_valid  <= 1'b0;
			frame_err  <= 1'b0;
			pend_break <= 1'b0;
			pend_ext   <= 1'b0;
		end else begin
			nextdata_n <= ~(rx_ready & nextdata_n); // one low cycle per word.
			key_valid  <= 1'b0;
			frame_err  <= 1'b0;
			if (consume) begin
				if (rx_err) begin
					frame_err  <= rx_word.err.stop_err | rx_word.err.parity_err;
					pend_break <= 1'b0; // a bad frame drops any half-read sequence.
					pend_ext   <= 1'b0;
				end else if (rx_word.code == `KBD_BREAK_CODE) begin
					pend_break <= 1'b1;
				end else if (rx_word.code == `KBD_EXT_CODE) begin
					pend_ext <= 1'b1;
				end else begin
					key_valid  <= 1'b1;
					pend_break <= 1'b0;
					pend_ext   <= 1'b0;
				end
			end
		end
	end

	// qualifiers are only looked at while key_valid is high.
	always_ff @(posedge clk) begin
		if (consume && !rx_err && !is_prefix) begin
			key_code  <= rx_word.code;
			key_break <= pend_break;
			key_ext   <= pend_ext;
		end
	end

endmodule

//--- hdl/key_tracker.sv
`timescale 1ns/1ns

module key_tracker (
	input  logic       clk,
	input  logic       rst,
	input  logic       key_valid,
	input  logic [7:0] key_code,
	input  logic       key_break,
	input  logic       key_ext,
	input  logic       frame_err,
	output logic [7:0] last_code,
	output logic       key_held,
	output logic       key_ext_seen,
	output logic [7:0] press_count,
	output logic [3:0] err_count
);

	logic make_evt;
	logic release_evt;

	assign make_evt    = key_valid & ~key_break;
	// releasing some other key leaves the shown key held.
	assign release_evt = key_valid & key_break & (key_code == last_code);

	// ----------------------------------------------------------------------
	// key state
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			last_code    <= 8'h00;
			key_held     <= 1'b0;
			key_ext_seen <= 1'b0;
			press_count  <= 8'h00;
		end else if (make_evt) begin
			last_code    <= key_code;
			key_ext_seen <= key_ext;
			key_held     <= 1'b1;
			press_count  <= press_count + 8'h01; // wraps after 255 presses.
		end else if (release_evt) begin
			key_held <= 1'b0;
		end
	end

	// ----------------------------------------------------------------------
	// error count
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			err_count <= 4'd0;
		end else if (frame_err && err_count != 4'd15) begin
			err_count <= err_count + 4'd1; // sticks at 15.
		end
	end

endmodule

//--- hdl/seg_display.sv
`timescale 1ns/1ns

module seg_display import kbd_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic [7:0] last_code,
	input  logic       key_held,
	input  logic [7:0] press_count,
	output logic [7:0] seg0,
	output logic [7:0] seg1,
	output logic [7:0] seg4,
	output logic [7:0] seg5
);

	logic [7:0] code_lo;
	logic [7:0] code_hi;
	logic [7:0] cnt_lo;
	logic [7:0] cnt_hi;

	// ----------------------------------------------------------------------
	// digit patterns
	// ----------------------------------------------------------------------

	always_comb begin
		if (key_held) begin
			code_lo = hex_to_seg(last_code[3:0]);
			code_hi = hex_to_seg(last_code[7:4]);
		end else begin
			code_lo = SEG_BLANK; // no key shown once it is released.
			code_hi = SEG_BLANK;
		end
		cnt_lo = hex_to_seg(press_count[3:0]);
		cnt_hi = hex_to_seg(press_count[7:4]);
	end

	// ----------------------------------------------------------------------
	// output registers
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			seg0 <= SEG_BLANK;
			seg1 <= SEG_BLANK;
			seg4 <= hex_to_seg(4'h0); // the count reads 00 after reset.
			seg5 <= hex_to_seg(4'h0);
		end else begin
			seg0 <= code_lo;
			seg1 <= code_hi;
			seg4 <= cnt_lo;
			seg5 <= cnt_hi;
		end
	end

endmodule

//--- hdl/kbd_top.sv
`timescale 1ns/1ns

module kbd_top import kbd_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       ps2_clk,
	input  logic       ps2_data,
	output logic [7:0] seg0,
	output logic [7:0] seg1,
	output logic [7:0] seg4,
	output logic [7:0] seg5,
	output logic       key_held,
	output logic       key_ext_seen,
	output logic [3:0] err_count
);

	ps2_word_u  rx_word;
	logic       rx_err;
	logic       rx_ready;
	logic       nextdata_n;
	logic       key_valid;
	logic [7:0] key_code;
	logic       key_break;
	logic       key_ext;
	logic       frame_err;
	logic [7:0] last_code;
	logic [7:0] press_count;

	// ----------------------------------------------------------------------
	// receive, decode, track, display
	// ----------------------------------------------------------------------

	ps2_frame_rx ps2_frame_rx_inst (
		.clk        (clk),
		.rst        (rst),
		.ps2_clk    (ps2_clk),
		.ps2_data   (ps2_data),
		.nextdata_n (nextdata_n),
		.rx_word    (rx_word),
		.rx_err     (rx_err),
		.rx_ready   (rx_ready)
	);

	scan_decoder scan_decoder_inst (
		.clk        (clk),
		.rst        (rst),
		.rx_word    (rx_word),
		.rx_err     (rx_err),
		.rx_ready   (rx_ready),
		.nextdata_n (nextdata_n),
		.key_valid  (key_valid),
		.key_code   (key_code),
		.key_break  (key_break),
		.key_ext    (key_ext),
		.frame_err  (frame_err)
	);

	key_tracker key_tracker_inst (
		.clk          (clk),
		.rst          (rst),
		.key_valid    (key_valid),
		.key_code     (key_code),
		.key_break    (key_break),
		.key_ext      (key_ext),
		.frame_err    (frame_err),
		.last_code    (last_code),
		.key_held     (key_held),
		.key_ext_seen (key_ext_seen),
		.press_count  (press_count),
		.err_count    (err_count)
	);

	seg_display seg_display_inst (
		.clk         (clk),
		.rst         (rst),
		.last_code   (last_code),
		.key_held    (key_held),
		.press_count (press_count),
		.seg0        (seg0),
		.seg1        (seg1),
		.seg4        (seg4),
		.seg5        (seg5)
	);

endmodule

//--- verif/kbd_sva.sv
`timescale 1ns/1ns

module kbd_sva (
	input logic clk,
	input logic rst,
	input logic rx_ready,
	input logic nextdata_n,
	input logic key_valid,
	input logic frame_err
);

	int fail_count; // read by the testbench at the end of the run.

	// ----------------------------------------------------------------------
	// receiver to decoder handshake
	// ----------------------------------------------------------------------

	ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
		!nextdata_n |=> nextdata_n)
		else begin
			fail_count++;
			$error("nextdata_n stayed low for more than one cycle");
		end

	ack_needs_ready: assert property (@(posedge clk) disable iff (rst)
		!nextdata_n |-> rx_ready)
		else begin
			fail_count++;
			$error("nextdata_n went low while rx_ready was low");
		end

	// a word is either a key event or a bad frame, never both.
	events_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(key_valid && frame_err))
		else begin
			fail_count++;
			$error("key_valid and frame_err were high in the same cycle");
		end

endmodule

// the decoder sees rx_ready as an input, so both sides of the handshake are visible here.
bind scan_decoder kbd_sva dec_sva_inst (
	.clk        (clk),
	.rst        (rst),
	.rx_ready   (rx_ready),
	.nextdata_n (nextdata_n),
	.key_valid  (key_valid),
	.frame_err  (frame_err)
);

//--- verif/kbd_tb.sv
`timescale 1ns/1ns
`include "kbd_settings.svh"

module kbd_tb;

	localparam int HALF_BIT        = 20; // clk cycles per ps2_clk half period.
	localparam int NUM_FRAMES      = 27; // frames sent by all tests together.
	localparam int WATCHDOG_CYCLES = NUM_FRAMES * 11 * 40 + 3000;

	logic       clk;
	logic       rst;
	logic       ps2_clk;
	logic       ps2_data;
	logic [7:0] seg0;
	logic [7:0] seg1;
	logic [7:0] seg4;
	logic [7:0] seg5;
	logic       key_held;
	logic       key_ext_seen;
	logic [3:0] err_count;

	logic [7:0] last_model; // expected tracker state, kept by the key tasks.
	logic       held_model;
	logic       ext_model;
	logic [7:0] count_model;
	logic [3:0] err_model;
	int         checks;
	int         errors;
	int         errs_at_start;
	int         tests;
	int         failed_tests;
	int         assert_fails;

	kbd_top kbd_top_inst (
		.clk          (clk),
		.rst          (rst),
		.ps2_clk      (ps2_clk),
		.ps2_data     (ps2_data),
		.seg0         (seg0),
		.seg1         (seg1),
		.seg4         (seg4),
		.seg5         (seg5),
		.key_held     (key_held),
		.key_ext_seen (key_ext_seen),
		.err_count    (err_count)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog: no result after %0d clock cycles", WATCHDOG_CYCLES);
		$display("TEST FAIL");
		$finish;
	end

	// ----------------------------------------------------------------------
	// expected values and compares
	// ----------------------------------------------------------------------

	// usual hex font, segments a..g, returned active low with the point dark.
	function automatic logic [7:0] digit_pattern(input logic [3:0] nibble);
		logic [6:0] lit;
		case (nibble)
			4'h0: lit = 7'b111_1110;
			4'h1: lit = 7'b011_0000;
			4'h2: lit = 7'b110_1101;
			4'h3: lit = 7'b111_1001;
			4'h4: lit = 7'b011_0011;
			4'h5: lit = 7'b101_1011;
			4'h6: lit = 7'b101_1111;
			4'h7: lit = 7'b111_0000;
			4'h8: lit = 7'b111_1111;
			4'h9: lit = 7'b111_1011;
			4'hA: lit = 7'b111_0111;
			4'hB: lit = 7'b001_1111;
			4'hC: lit = 7'b100_1110;
			4'hD: lit = 7'b011_1101;
			4'hE: lit = 7'b100_1111;
			default: lit = 7'b100_0111;
		endcase
		return {~lit, 1'b1};
	endfunction

	task automatic seg_equal(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks = checks + 1;
		if (got !== exp) begin
			errors = errors + 1;
			$display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic count_equal(input string name, input logic [3:0] got, input logic [3:0] exp);
		checks = checks + 1;
		if (got !== exp) begin
			errors = errors + 1;
			$display("[FAIL] %0t %s: got %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic flag_equal(input string name, input logic got, input logic exp);
		checks = checks + 1;
		if (got !== exp) begin
			errors = errors + 1;
			$display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic state_check();
		flag_equal("key_held", key_held, held_model);
		flag_equal("key_ext_seen", key_ext_seen, ext_model);
		count_equal("err_count", err_count, err_model);
		seg_equal("seg0", seg0, held_model ? digit_pattern(last_model[3:0]) : 8'hFF);
		seg_equal("seg1", seg1, held_model ? digit_pattern(last_model[7:4]) : 8'hFF);
		seg_equal("seg4", seg4, digit_pattern(count_model[3:0]));
		seg_equal("seg5", seg5, digit_pattern(count_model[7:4]));
	endtask

	task automatic report_test(input string name);
		tests = tests + 1;
		if (errors == errs_at_start) begin
			$display("%s: ok", name);
		end else begin
			failed_tests = failed_tests + 1;
			$display("%s: %0d mismatches", name, errors - errs_at_start);
		end
		errs_at_start = errors;
	endtask

	// ----------------------------------------------------------------------
	// PS/2 driver and key sequences
	// ----------------------------------------------------------------------

	task automatic settle();
		repeat (20) @(negedge clk);
	endtask

	task automatic send_frame(input logic [7:0] data, input logic bad_parity,
			input logic bad_stop);
		logic [10:0] frame;
		frame = {~bad_stop, ~(^data) ^ bad_parity, data, 1'b0}; // stop, odd parity, data, start.
		for (int i = 0; i < 11; i++) begin
			ps2_data = frame[i]; // data changes while ps2_clk is high.
			repeat (HALF_BIT) @(negedge clk);
			ps2_clk = 1'b0;
			repeat (HALF_BIT) @(negedge clk);
			ps2_clk = 1'b1;
		end
		ps2_data = 1'b1;
		repeat (HALF_BIT) @(negedge clk);
	endtask

	task automatic press_key(input logic [7:0] code, input logic ext);
		if (ext) begin
			send_frame(`KBD_EXT_CODE, 1'b0, 1'b0);
		end
		send_frame(code, 1'b0, 1'b0);
		settle();
		last_model  = code;
		held_model  = 1'b1;
		ext_model   = ext;
		count_model = count_model + 8'd1;
	endtask

	task automatic release_key(input logic [7:0] code, input logic ext);
		if (ext) begin
			send_frame(`KBD_EXT_CODE, 1'b0, 1'b0);
		end
		send_frame(`KBD_BREAK_CODE, 1'b0, 1'b0);
		send_frame(code, 1'b0, 1'b0);
		settle();
		if (code == last_model) begin
			held_model = 1'b0; // only the shown key can be released.
		end
	endtask

	// ----------------------------------------------------------------------
	// directed tests
	// ----------------------------------------------------------------------

	task automatic single_make();
		state_check(); // reset state first.
		press_key(8'h1C, 1'b0);
		state_check();
		report_test("single_make");
	endtask

	task automatic make_then_break();
		press_key(8'h1C, 1'b0);
		state_check();
		release_key(8'h1C, 1'b0);
		state_check();
		report_test("make_then_break");
	endtask

	task automatic extended_make();
		press_key(8'h75, 1'b1);
		state_check();
		report_test("extended_make");
	endtask

	task automatic bad_frame_recovery();
		send_frame(8'h33, 1'b1, 1'b0);
		send_frame(8'h44, 1'b0, 1'b1);
		settle();
		err_model = err_model + 4'd2;
		state_check();
		press_key(8'h5A, 1'b0);
		state_check();
		report_test("bad_frame_recovery");
	endtask

	task automatic random_keys();
		logic [7:0] code;
		repeat (6) begin
			code = 8'h01 + 8'($urandom % 223); // 01 to DF, clear of both prefixes.
			press_key(code, 1'b0);
			state_check();
			release_key(code, 1'b0);
			state_check();
		end
		report_test("random_keys");
	endtask

	function automatic int sva_failures();
		return kbd_top_inst.scan_decoder_inst.dec_sva_inst.fail_count;
	endfunction

	initial begin
		void'($urandom(32'h5902_0abe));
		rst           = 1'b1;
		ps2_clk       = 1'b1; // bus idles high.
		ps2_data      = 1'b1;
		last_model    = 8'h00;
		held_model    = 1'b0;
		ext_model     = 1'b0;
		count_model   = 8'h00;
		err_model     = 4'd0;
		checks        = 0;
		errors        = 0;
		errs_at_start = 0;
		tests         = 0;
		failed_tests  = 0;
		repeat (4) @(negedge clk);
		rst = 1'b0;
		settle();
		single_make();
		make_then_break();
		extended_make();
		bad_frame_recovery();
		random_keys();
		assert_fails = sva_failures();
		$display("%0d tests, %0d failed, %0d checks, %0d mismatches, %0d sva failures",
			tests, failed_tests, checks, errors, assert_fails);
		if (errors == 0 && assert_fails == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

//--- list.f
+incdir+include
hdl/kbd_pkg.sv
hdl/ps2_frame_rx.sv
hdl/scan_decoder.sv
hdl/key_tracker.sv
hdl/seg_display.sv
hdl/kbd_top.sv
verif/kbd_sva.sv
verif/kbd_tb.sv

//--- Makefile
TOP := kbd_tb

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f list.f -o $(TOP)_sim
	./obj_dir/$(TOP)_sim | tee sim.log
	grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
